/* design/HdmiPkg.sv */
// Shared definitions for the HDMI data island header encoder
// Packet type enum, header and parity widths, packet length,
// BCH generator taps and the TERC4 code word table

package HdmiPkg;

    // Packet types the sink is known to understand
    // Anything else on the input is replaced by nullPacket in decode
    typedef enum logic [7:0] {
        nullPacket      = 8'h00,
        audioClockRegen = 8'h01,
        audioSample     = 8'h02,
        generalControl  = 8'h03,
        aviInfoFrame    = 8'h82,
        audioInfoFrame  = 8'h84
    } packetTypeE;

    // Header data bits: type byte plus two header bytes
    localparam int headerBits = 24;

    // BCH(32,24) parity bits appended after the header data
    localparam int eccBits = 8;

    // One header bit per pixel clock, so this is also the packet length in pixels
    localparam int packetPixels = headerBits + eccBits;

    // Generator x^8+x^7+x^6+1 in bit-reversed form for an LSB-first shift register
    localparam logic [eccBits-1:0] eccTaps = 8'h83;

    // TERC4 maps each 4-bit nibble to one 10-bit code word
    localparam int terc4Entries = 16;

    // Code words indexed by nibble value, as listed in the HDMI specification
    localparam logic [9:0] terc4Table [terc4Entries] = '{
        10'b1010011100,
        10'b1001100011,
        10'b1011100100,
        10'b1011100010,
        10'b0101110001,
        10'b0100011110,
        10'b0110001110,
        10'b0100111100,
        10'b1011001100,
        10'b0100111001,
        10'b0110011100,
        10'b1011000110,
        10'b1010001110,
        10'b1001110001,
        10'b0101100011,
        10'b1011000011
    };

endpackage

/* design/BchEccStep.sv */
// One combinational step of the HDMI header BCH shift register
// Takes one data bit and the running parity, returns the next parity

`timescale 1ns/1ps

module BchEccStep (
    input  logic                        data,
    input  logic [HdmiPkg::eccBits-1:0] ecc,
    output logic [HdmiPkg::eccBits-1:0] eccNext
);

    logic feedback;

    always_comb begin
        // The incoming bit meets the bit that is about to leave the register
        feedback = data ^ ecc[0];

        // Shift toward bit 0 and fold the feedback back in through the generator taps
        // When feedback is 0 this is a plain shift
        eccNext = {1'b0, ecc[HdmiPkg::eccBits-1:1]};
        if (feedback) begin
            eccNext = eccNext ^ HdmiPkg::eccTaps;
        end
    end

endmodule

/* design/BchEccSingleBitEncoder.sv */
// Running BCH parity for one HDMI packet header, one bit per pixel clock
// Header bits enter LSB first, then the parity leaves on ecc bit 0 first

`timescale 1ns/1ps

module BchEccSingleBitEncoder (
    input  logic clock,
    input  logic rstN,
    input  logic data,
    input  logic isFirstDataBit,
    output logic ecc
);

    logic [HdmiPkg::eccBits-1:0] eccReg;
    logic [HdmiPkg::eccBits-1:0] eccSeed;
    logic [HdmiPkg::eccBits-1:0] eccNext;
    // Counts header data bits seen since the first one, stops at headerBits
    logic [4:0]                  bitCount;
    logic                        dataPhase;
    logic                        stepData;

    always_comb begin
        // A new header starts from an all-zero parity, so headers may follow with no gap
        eccSeed = isFirstDataBit ? '0 : eccReg;
        dataPhase = isFirstDataBit || (bitCount < 5'(HdmiPkg::headerBits));
        // Once the data bits are done the feedback is cancelled and the register just shifts
        // out the parity in order while the data input sits low
        stepData = dataPhase ? data : eccReg[0];
    end

    BchEccStep bchStep (
        .data    (stepData),
        .ecc     (eccSeed),
        .eccNext (eccNext)
    );

    always_ff @(posedge clock) begin
        if (!rstN) begin
            eccReg <= '0;
            bitCount <= 5'(HdmiPkg::headerBits);
        end else begin
            eccReg <= eccNext;
            if (isFirstDataBit) begin
                bitCount <= 5'd1;
            end else if (dataPhase) begin
                bitCount <= bitCount + 5'd1;
            end
        end
    end

    assign ecc = eccReg[0];

endmodule

/* design/PacketHeaderDecode.sv */
// Decode stage of the header encoder
// One-entry buffer on the valid/ready input, with a packet type check that
// turns unknown types into a null packet

`timescale 1ns/1ps

module PacketHeaderDecode (
    input  logic                           clock,
    input  logic                           rstN,
    input  logic                           headerValid,
    output logic                           headerReady,
    input  logic [7:0]                     packetType,
    input  logic [7:0]                     headerByte1,
    input  logic [7:0]                     headerByte2,
    output logic                           loadValid,
    input  logic                           loadReady,
    output logic [HdmiPkg::headerBits-1:0] loadHeader
);

    logic                           full;
    logic                           fullNext;
    logic                           knownType;
    logic [HdmiPkg::headerBits-1:0] entry;

    // Only the enum members pass through unchanged
    always_comb begin
        case (packetType)
            HdmiPkg::nullPacket,
            HdmiPkg::audioClockRegen,
            HdmiPkg::audioSample,
            HdmiPkg::generalControl,
            HdmiPkg::aviInfoFrame,
            HdmiPkg::audioInfoFrame: knownType = 1'b1;
            default:                 knownType = 1'b0;
        endcase
    end

    // Accepting needs an empty buffer, so a fill and a release never meet in one cycle
    always_comb begin
        fullNext = full;
        if (headerValid && headerReady) begin
            fullNext = 1'b1;
        end else if (loadReady) begin
            fullNext = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            full <= 1'b0;
            headerReady <= 1'b0;
        end else begin
            full <= fullNext;
            // Ready is registered so it stays low through reset
            headerReady <= !fullNext;
        end
    end

    // Bits 7:0 are the type, then byte 1 and byte 2, which is also transmission order
    always_ff @(posedge clock) begin
        if (headerValid && headerReady) begin
            if (knownType) begin
                entry <= {headerByte2, headerByte1, packetType};
            end else begin
                entry <= {16'h0000, HdmiPkg::nullPacket};
            end
        end
    end

    assign loadValid = full;
    assign loadHeader = entry;

endmodule

/* design/HeaderSerializer.sv */
// Execute stage of the header encoder
// Sends the 24 header bits LSB first, then the 8 BCH parity bits,
// one bit per pixel clock, and can take the next header on the last pixel

`timescale 1ns/1ps

module HeaderSerializer (
    input  logic                           clock,
    input  logic                           rstN,
    input  logic                           loadValid,
    output logic                           loadReady,
    input  logic [HdmiPkg::headerBits-1:0] loadHeader,
    output logic                           bitValid,
    output logic                           headerBit,
    output logic                           firstPixel
);

    typedef enum logic {
        idle,
        sending
    } stateE;

    stateE                          state;
    // Pixel index within the packet, 0 to packetPixels-1
    logic [4:0]                     pixelCount;
    logic [HdmiPkg::headerBits-1:0] shiftReg;
    logic                           lastPixel;
    logic                           dataPixel;
    logic                           encoderData;
    logic                           eccBit;
    logic                           load;

    always_comb begin
        lastPixel = (state == sending) && (pixelCount == 5'(HdmiPkg::packetPixels - 1));
        dataPixel = pixelCount < 5'(HdmiPkg::headerBits);
        // Ready while idle and on the last pixel, so a waiting header follows with no gap
        loadReady = (state == idle) || lastPixel;
        load = loadValid && loadReady;
        // The parity register sees header bits, then a low input during the parity pixels
        encoderData = (state == sending) && dataPixel && shiftReg[0];
    end

    assign bitValid = (state == sending);
    assign firstPixel = (state == sending) && (pixelCount == 5'd0);
    assign headerBit = dataPixel ? shiftReg[0] : eccBit;

    BchEccSingleBitEncoder eccEncoder (
        .clock          (clock),
        .rstN           (rstN),
        .data           (encoderData),
        .isFirstDataBit (firstPixel),
        .ecc            (eccBit)
    );

    always_ff @(posedge clock) begin
        if (!rstN) begin
            state <= idle;
            pixelCount <= 5'd0;
        end else if (load) begin
            state <= sending;
            pixelCount <= 5'd0;
        end else if (lastPixel) begin
            // Nothing waiting, so the line goes quiet until the next header
            state <= idle;
            pixelCount <= 5'd0;
        end else if (state == sending) begin
            pixelCount <= pixelCount + 5'd1;
        end
    end

    // Header bits leave from bit 0, the rest moves down one place per pixel
    always_ff @(posedge clock) begin
        if (load) begin
            shiftReg <= loadHeader;
        end else if (state == sending) begin
            shiftReg <= {1'b0, shiftReg[HdmiPkg::headerBits-1:1]};
        end
    end

endmodule

/* design/Terc4Channel0.sv */
// Result stage of the header encoder
// Builds the TMDS channel 0 nibble for a data island and registers its
// TERC4 code word

`timescale 1ns/1ps

module Terc4Channel0 (
    input  logic       clock,
    input  logic       rstN,
    input  logic       bitValid,
    input  logic       headerBit,
    input  logic       firstPixel,
    input  logic       hsync,
    input  logic       vsync,
    output logic [9:0] symbol,
    output logic       symbolValid
);

    logic [3:0] nibble;

    // Channel 0 carries the syncs in bits 1:0 and the header bit in bit 2
    // Bit 3 is low only on the first pixel of a packet
    always_comb begin
        nibble = {~firstPixel, headerBit, vsync, hsync};
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            symbolValid <= 1'b0;
        end else begin
            symbolValid <= bitValid;
        end
    end

    // The code word lines up with symbolValid, one cycle after the bit
    always_ff @(posedge clock) begin
        symbol <= HdmiPkg::terc4Table[nibble];
    end

endmodule

/* design/HdmiHeaderEncoder.sv */
// Top level of the HDMI data island header encoder
// Decode checks the type, execute serializes header and parity,
// result TERC4-encodes channel 0

`timescale 1ns/1ps

module HdmiHeaderEncoder (
    input  logic       clock,
    input  logic       rstN,
    input  logic       headerValid,
    output logic       headerReady,
    input  logic [7:0] packetType,
    input  logic [7:0] headerByte1,
    input  logic [7:0] headerByte2,
    input  logic       hsync,
    input  logic       vsync,
    output logic [9:0] symbol,
    output logic       symbolValid
);

    // Decode to execute, a valid/ready pair with the checked header
    logic                           loadValid;
    logic                           loadReady;
    logic [HdmiPkg::headerBits-1:0] loadHeader;

    // Execute to result, no handshake since the pixel clock never stops
    logic                           bitValid;
    logic                           headerBit;
    logic                           firstPixel;

    PacketHeaderDecode decode (
        .clock       (clock),
        .rstN        (rstN),
        .headerValid (headerValid),
        .headerReady (headerReady),
        .packetType  (packetType),
        .headerByte1 (headerByte1),
        .headerByte2 (headerByte2),
        .loadValid   (loadValid),
        .loadReady   (loadReady),
        .loadHeader  (loadHeader)
    );

    HeaderSerializer execute (
        .clock      (clock),
        .rstN       (rstN),
        .loadValid  (loadValid),
        .loadReady  (loadReady),
        .loadHeader (loadHeader),
        .bitValid   (bitValid),
        .headerBit  (headerBit),
        .firstPixel (firstPixel)
    );

    Terc4Channel0 result (
        .clock       (clock),
        .rstN        (rstN),
        .bitValid    (bitValid),
        .headerBit   (headerBit),
        .firstPixel  (firstPixel),
        .hsync       (hsync),
        .vsync       (vsync),
        .symbol      (symbol),
        .symbolValid (symbolValid)
    );

endmodule

/* tb/ClockGen.sv */
// Testbench clock and reset source
// 4 ns clock, rstN held low for the first 4 cycles

`timescale 1ns/1ps

module ClockGen (
    output logic clock,
    output logic rstN
);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Reset leaves on a falling edge, like every other input of the DUT
    initial begin
        rstN = 1'b0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        rstN = 1'b1;
    end

endmodule

/* tb/HdmiHeaderEncoder_properties.sv */
// Concurrent protocol checks for the header encoder ports
// Reset behavior, back-pressure, source hold under back-pressure and start latency

`timescale 1ns/1ps

module HdmiHeaderEncoder_properties (
    input logic       clock,
    input logic       rstN,
    input logic       headerValid,
    input logic       headerReady,
    input logic [7:0] packetType,
    input logic [7:0] headerByte1,
    input logic [7:0] headerByte2,
    input logic       symbolValid
);

    // Any cycle spent in reset leaves both outputs low
    resetQuiet: assert property (@(posedge clock) !rstN |=> !headerReady && !symbolValid)
        else $error("headerReady or symbolValid is high right after a reset cycle");

    // The empty input buffer shows up one cycle after reset is released
    readyAfterReset: assert property (@(posedge clock) $rose(rstN) |=> headerReady)
        else $error("headerReady did not rise after reset was released");

    // An accepted header fills the one-entry buffer, so ready must drop in the next cycle
    fullBlocksReady: assert property (@(posedge clock) disable iff (!rstN)
        headerValid && headerReady |=> !headerReady)
        else $error("headerReady stayed high although the buffer was just filled");

    // A stalled header keeps its valid and its fields until it is taken
    holdUnderStall: assert property (@(posedge clock) disable iff (!rstN)
        headerValid && !headerReady |=> headerValid && $stable(packetType)
            && $stable(headerByte1) && $stable(headerByte2))
        else $error("Header fields changed while the transfer was stalled");

    // From an idle line the first symbol comes three cycles after acceptance
    idleLatency: assert property (@(posedge clock) disable iff (!rstN)
        headerValid && headerReady && !symbolValid |-> ##3 symbolValid)
        else $error("No symbol three cycles after a header was accepted on an idle line");

    // and never earlier, since every new run of symbols traces back to one acceptance
    startLatency: assert property (@(posedge clock) disable iff (!rstN)
        $rose(symbolValid) |-> $past(headerValid && headerReady, 3))
        else $error("A packet started without an acceptance three cycles before");

endmodule

/* tb/HdmiHeaderEncoder_tb.sv */
// Testbench for the HDMI header encoder
// LFSR stimulus, a reference packet and parity model, symbol checks on
// every valid pixel, error counts, a cycle timeout and the closing line

`timescale 1ns/1ps

module HdmiHeaderEncoder_tb;

    logic       clock;
    logic       rstN;
    logic       headerValid;
    logic       headerReady;
    logic [7:0] packetType;
    logic [7:0] headerByte1;
    logic [7:0] headerByte2;
    logic       hsync;
    logic       vsync;
    logic [9:0] symbol;
    logic       symbolValid;

    // Test lengths in packets, which also set the timeout
    int knownCount = 6;
    int unknownCount = 3;
    int burstCount = 5;
    int cycleLimit;
    int cycles = 0;
    int symbolErrors = 0;
    int protocolErrors = 0;
    int accepted = 0;
    int received = 0;

    logic [15:0] lfsr = 16'd56617;
    // Whole 32-bit packets in send order, header in bits 23:0 and parity above
    logic [31:0] expected [$];
    logic [31:0] current;
    logic [4:0]  pixel = 5'd0;
    logic        lastValid = 1'b0;
    logic        burst = 1'b0;

    HdmiPkg::packetTypeE knownTypes [6] = '{HdmiPkg::nullPacket, HdmiPkg::audioClockRegen,
        HdmiPkg::audioSample, HdmiPkg::generalControl, HdmiPkg::aviInfoFrame,
        HdmiPkg::audioInfoFrame};

    ClockGen clockGen (.clock(clock), .rstN(rstN));

    HdmiHeaderEncoder UUT (
        .clock(clock), .rstN(rstN), .headerValid(headerValid), .headerReady(headerReady),
        .packetType(packetType), .headerByte1(headerByte1), .headerByte2(headerByte2),
        .hsync(hsync), .vsync(vsync), .symbol(symbol), .symbolValid(symbolValid)
    );

    bind HdmiHeaderEncoder HdmiHeaderEncoder_properties protocolChecks (
        .clock(clock), .rstN(rstN), .headerValid(headerValid), .headerReady(headerReady),
        .packetType(packetType), .headerByte1(headerByte1), .headerByte2(headerByte2),
        .symbolValid(symbolValid)
    );

    // Fibonacci LFSR x^16+x^14+x^13+x^11+1, one step per bit handed out
    function automatic logic nextBit();
        logic feedback;
        feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], feedback};
        return feedback;
    endfunction

    function automatic logic [7:0] randomBits(input int count);
        logic [7:0] value;
        value = 8'h00;
        for (int i = 0; i < count; i++) begin
            value = {value[6:0], nextBit()};
        end
        return value;
    endfunction

    // Unknown types become an all-zero null header before the parity is formed
    // Generator x^8+x^7+x^6+1 reflected for an LSB-first register gives taps 8'h83
    function automatic logic [31:0] packetBits(input logic [7:0] t, input logic [7:0] b1,
                                               input logic [7:0] b2);
        logic [23:0] hdr;
        logic [7:0]  parity;
        logic        feedback;
        case (t)
            HdmiPkg::nullPacket, HdmiPkg::audioClockRegen, HdmiPkg::audioSample,
            HdmiPkg::generalControl, HdmiPkg::aviInfoFrame, HdmiPkg::audioInfoFrame:
                hdr = {b2, b1, t};
            default: hdr = 24'h000000;
        endcase
        parity = 8'h00;
        for (int i = 0; i < 24; i++) begin
            feedback = hdr[i] ^ parity[0];
            parity = {1'b0, parity[7:1]} ^ (feedback ? 8'h83 : 8'h00);
        end
        return {parity, hdr};
    endfunction

    // One clock at the falling edge: check the symbol, then drive new syncs
    // The syncs still on the inputs are the ones the last rising edge encoded
    task automatic cycle();
        logic [3:0] nibble;
        @(negedge clock);
        if (symbolValid) begin
            if (pixel == 5'd0) begin
                assert (expected.size() != 0) else begin
                    $display("A packet started with no accepted header waiting for it");
                    protocolErrors++;
                end
                current = 32'h0;
                if (expected.size() != 0) begin
                    current = expected.pop_front();
                end
                received++;
            end
            nibble = {pixel != 5'd0, current[pixel], vsync, hsync};
            assert (symbol == HdmiPkg::terc4Table[nibble]) else begin
                $display("FAILED symbol packet %0d pixel %0d: got %h expected %h",
                         received, pixel, symbol, HdmiPkg::terc4Table[nibble]);
                symbolErrors++;
            end
            pixel = pixel + 5'd1;
        end else begin
            assert (pixel == 5'd0) else begin
                $display("symbolValid dropped after %0d symbols of a packet", pixel);
                protocolErrors++;
                pixel = 5'd0;
            end
            assert (!(burst && lastValid) || expected.size() == 0) else begin
                $display("Idle cycle between back-to-back packets");
                protocolErrors++;
            end
        end
        lastValid = symbolValid;
        hsync = nextBit();
        vsync = nextBit();
    endtask

    // Offers one header and holds it until the DUT is ready to take it
    task automatic sendHeader(input logic knownType);
        logic [2:0] pick;
        cycle();
        if (knownType) begin
            pick = 3'(randomBits(3) % 8'd6);
            packetType = knownTypes[pick];
        end else begin
            // 0x40 to 0x7F holds no enum member
            packetType = 8'h40 | randomBits(6);
        end
        headerByte1 = randomBits(8);
        headerByte2 = randomBits(8);
        headerValid = 1'b1;
        while (!headerReady) begin
            cycle();
        end
        expected.push_back(packetBits(packetType, headerByte1, headerByte2));
        accepted++;
    endtask

    task automatic drain();
        cycle();
        headerValid = 1'b0;
        while (expected.size() != 0 || symbolValid) begin
            cycle();
        end
    endtask

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles > cycleLimit) begin
            $display("Timeout after %0d cycles with packets still outstanding", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        cycleLimit = (knownCount + unknownCount + burstCount) * 40 + 100;
        headerValid = 1'b0;
        packetType = 8'h00;
        headerByte1 = 8'h00;
        headerByte2 = 8'h00;
        hsync = 1'b0;
        vsync = 1'b0;
        wait (rstN);
        for (int i = 0; i < knownCount; i++) begin
            sendHeader(1'b1);
            drain();
        end
        for (int i = 0; i < unknownCount; i++) begin
            sendHeader(1'b0);
            drain();
        end
        // Valid stays high through the burst, so the buffer is full most of the time
        burst = 1'b1;
        for (int i = 0; i < burstCount; i++) begin
            sendHeader((i % 2) == 0);
        end
        drain();
        assert (accepted == received && expected.size() == 0) else begin
            $display("%0d headers were accepted but %0d packets arrived", accepted, received);
            protocolErrors++;
        end
        $display("Errors: %0d symbol, %0d protocol, over %0d packets",
                 symbolErrors, protocolErrors, received);
        if (symbolErrors + protocolErrors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* HdmiHeaderEncoder.f */
design/HdmiPkg.sv
design/BchEccStep.sv
design/BchEccSingleBitEncoder.sv
design/PacketHeaderDecode.sv
design/HeaderSerializer.sv
design/Terc4Channel0.sv
design/HdmiHeaderEncoder.sv
tb/ClockGen.sv
tb/HdmiHeaderEncoder_properties.sv
tb/HdmiHeaderEncoder_tb.sv

/* run.sh */
#!/bin/sh
# Builds the header encoder testbench with Verilator, runs it and scans sim.log for failure
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module HdmiHeaderEncoder_tb \
        -f HdmiHeaderEncoder.f -Mdir obj_dir > sim.log 2>&1 \
    && ./obj_dir/VHdmiHeaderEncoder_tb >> sim.log 2>&1 \
    || echo ">>> FAIL" >> sim.log
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1 || exit 0
